// ==== hdl/csr_params.svh ====
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Datapath widths
`define XLEN       32
`define COUNTER_W  64
`define ECODE_W    5
`define RETIRE_W   2
`define CSR_ADDR_W 12

// Reset and identification values
`define RESET_MTVEC 32'h0000_0100
`define HART_ID     32'h0000_0000

// Machine-mode CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MIP       12'h344
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRETH 12'hB82
`define CSR_MHARTID   12'hF14

// Machine interrupt cause codes match their mip/mie bit positions
`define IRQ_M_SOFT  3
`define IRQ_M_TIMER 7
`define IRQ_M_EXT   11

// mstatus field positions
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

`endif

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    `include "csr_params.svh"

    //////////////////////////////
    // Encodings

    // Low two bits of funct3 in the CSR instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        ISSUE_IDLE = 2'b00,
        ISSUE_EXEC = 2'b01,
        ISSUE_ACK  = 2'b10
    } issue_state_e;

    //////////////////////////////
    // Request path

    // Request as presented on the req/ack port
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0] addr;
        csr_op_e                op;
        logic [`XLEN-1:0]       data;
    } csr_req_t;

    // Write command that is valid for one cycle per request
    typedef struct packed {
        logic                   valid;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } csr_write_t;

    //////////////////////////////
    // Core side

    typedef struct packed {
        logic software;
        logic timer;
        logic external;
    } m_irq_t;

    typedef struct packed {
        logic                valid;
        logic [`ECODE_W-1:0] code;
        logic [`XLEN-1:0]    pc;
    } exception_t;

    //////////////////////////////
    // Register views for the read mux

    // Trap registers as they read back
    typedef struct packed {
        logic [`XLEN-1:0] mstatus;
        logic [`XLEN-1:0] mie;
        logic [`XLEN-1:0] mip;
        logic [`XLEN-1:0] mtvec;
        logic [`XLEN-1:0] mepc;
        logic [`XLEN-1:0] mcause;
        logic [`XLEN-1:0] mscratch;
    } trap_csr_t;

    typedef struct packed {
        logic [`COUNTER_W-1:0] mcycle;
        logic [`COUNTER_W-1:0] minstret;
    } counter_csr_t;

endpackage

// ==== hdl/csr_issue_stage.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_issue_stage
    import csr_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  csr_req_t         req_data,
    output logic             ack,
    output logic [`XLEN-1:0] rdata,
    input  logic [`XLEN-1:0] old_value,
    output logic             start,
    output csr_req_t         cur_req
);

    issue_state_e state;
    issue_state_e next_state;
    logic         accept;
    logic         finish;

    // New request only from idle, so one request in flight
    assign accept = (state == ISSUE_IDLE) && req;

    // Old value is registered by the second EXEC cycle
    assign finish = (state == ISSUE_EXEC) && !start;

    //////////////////////////////
    // Handshake FSM

    always_comb begin
        next_state = state;
        case (state)
            ISSUE_IDLE: begin
                if (accept) begin
                    next_state = ISSUE_EXEC;
                end
            end
            ISSUE_EXEC: begin
                if (finish) begin
                    next_state = ISSUE_ACK;
                end
            end
            ISSUE_ACK: begin
                // Hold ack until the requester lets go
                if (!req) begin
                    next_state = ISSUE_IDLE;
                end
            end
            default: begin
                next_state = ISSUE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ISSUE_IDLE;
            start <= 1'b0;
        end else begin
            state <= next_state;
            start <= accept;
        end
    end

    //////////////////////////////
    // Request and response data

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_req <= req_data;
        end
        if (finish) begin
            rdata <= old_value;
        end
    end

    assign ack = (state == ISSUE_ACK);

    // A rising ack answers a request the requester still holds
    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> (req && $past(req)));

endmodule

// ==== hdl/csr_rmw_stage.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_rmw_stage
    import csr_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  csr_req_t         cur_req,
    input  trap_csr_t        trap,
    input  counter_csr_t     cnt,
    output logic [`XLEN-1:0] old_value,
    output csr_write_t       wr
);

    // MXL = 32 bit, I extension only
    localparam logic [`XLEN-1:0] MISA_VALUE = 32'h4000_0100;

    logic [`XLEN-1:0] selected;
    logic [`XLEN-1:0] updated;
    logic             read_only;
    logic             pure_read;

    //////////////////////////////
    // Read mux

    always_comb begin
        case (cur_req.addr)
            `CSR_MSTATUS:   selected = trap.mstatus;
            `CSR_MISA:      selected = MISA_VALUE;
            `CSR_MIE:       selected = trap.mie;
            `CSR_MTVEC:     selected = trap.mtvec;
            `CSR_MSCRATCH:  selected = trap.mscratch;
            `CSR_MEPC:      selected = trap.mepc;
            `CSR_MCAUSE:    selected = trap.mcause;
            `CSR_MIP:       selected = trap.mip;
            `CSR_MCYCLE:    selected = cnt.mcycle[`XLEN-1:0];
            `CSR_MCYCLEH:   selected = cnt.mcycle[`COUNTER_W-1:`XLEN];
            `CSR_MINSTRET:  selected = cnt.minstret[`XLEN-1:0];
            `CSR_MINSTRETH: selected = cnt.minstret[`COUNTER_W-1:`XLEN];
            `CSR_MHARTID:   selected = `HART_ID;
            default:        selected = '0;
        endcase
    end

    //////////////////////////////
    // Read-modify-write

    always_comb begin
        case (cur_req.op)
            CSR_RS:  updated = selected | cur_req.data;
            CSR_RC:  updated = selected & ~cur_req.data;
            default: updated = cur_req.data;
        endcase
    end

    assign read_only = (cur_req.addr == `CSR_MISA)
                    || (cur_req.addr == `CSR_MHARTID)
                    || (cur_req.addr == `CSR_MIP);

    // Set or clear with an empty mask is a plain read
    // and must not stall a counter
    assign pure_read = (cur_req.op != CSR_RW) && (cur_req.data == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr.valid <= 1'b0;
        end else begin
            wr.valid <= start && !read_only && !pure_read;
        end
        if (start) begin
            old_value <= selected;
            wr.addr   <= cur_req.addr;
            wr.data   <= updated;
        end
    end

    // One write command per accepted request
    wr_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wr.valid |=> !wr.valid);

endmodule

// ==== hdl/csr_trap_regs.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_trap_regs
    import csr_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  csr_write_t       wr,
    input  m_irq_t           m_irq,
    input  exception_t       exception,
    input  logic             mret,
    input  logic             interrupt_taken,
    output trap_csr_t        trap,
    output logic [`XLEN-1:0] trap_vector,
    output logic [`XLEN-1:0] epc,
    output logic             interrupt_pending
);

    // Machine interrupt bits double as the legal interrupt codes
    localparam logic [`XLEN-1:0] IRQ_MASK = (`XLEN'(1) << `IRQ_M_SOFT)
                                          | (`XLEN'(1) << `IRQ_M_TIMER)
                                          | (`XLEN'(1) << `IRQ_M_EXT);
    // Exception codes 0, 2, 3, 4, 6 and 11 exist in machine mode
    localparam logic [`XLEN-1:0] EXC_LEGAL = 32'h0000_085D;

    logic                mstatus_mie;
    logic                mstatus_mpie;
    logic [`XLEN-1:0]    mstatus;
    logic [`XLEN-1:0]    mtvec;
    logic [`XLEN-1:0]    mepc;
    logic                mcause_irq;
    logic [`ECODE_W-1:0] mcause_code;
    logic [`XLEN-1:0]    mcause;
    logic [`XLEN-1:0]    mie;
    logic [`XLEN-1:0]    mip;
    logic [`XLEN-1:0]    mip_lines;
    logic [`XLEN-1:0]    mscratch;
    logic [`XLEN-1:0]    irq_active;
    logic [`ECODE_W-1:0] irq_cause;
    logic [`ECODE_W-1:0] irq_cause_r;
    logic                trap_entry;
    logic                mcause_write_legal;

    assign trap_entry = exception.valid || interrupt_taken;

    //////////////////////////////
    // mstatus

    always_comb begin
        mstatus = '0;
        mstatus[`MSTATUS_MIE]  = mstatus_mie;
        mstatus[`MSTATUS_MPIE] = mstatus_mpie;
        // MPP fixed at machine
        mstatus[12:11] = 2'b11;
    end

    // CSR write beats trap entry and mret here
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end else if (wr.valid && (wr.addr == `CSR_MSTATUS)) begin
            mstatus_mie  <= wr.data[`MSTATUS_MIE];
            mstatus_mpie <= wr.data[`MSTATUS_MPIE];
        end else if (trap_entry) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end
    end

    //////////////////////////////
    // Vector, epc, scratch, enables

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= `RESET_MTVEC;
            mepc     <= '0;
            mscratch <= '0;
            mie      <= '0;
            mip      <= '0;
        end else begin
            if (wr.valid && (wr.addr == `CSR_MTVEC)) begin
                mtvec <= {wr.data[`XLEN-1:2], 2'b00};
            end
            // Trap entry wins over a software write
            if (trap_entry) begin
                mepc <= {exception.pc[`XLEN-1:2], 2'b00};
            end else if (wr.valid && (wr.addr == `CSR_MEPC)) begin
                mepc <= {wr.data[`XLEN-1:2], 2'b00};
            end
            if (wr.valid && (wr.addr == `CSR_MSCRATCH)) begin
                mscratch <= wr.data;
            end
            if (wr.valid && (wr.addr == `CSR_MIE)) begin
                mie <= wr.data & IRQ_MASK;
            end
            mip <= mip_lines;
        end
    end

    //////////////////////////////
    // Interrupts

    always_comb begin
        mip_lines = '0;
        mip_lines[`IRQ_M_SOFT]  = m_irq.software;
        mip_lines[`IRQ_M_TIMER] = m_irq.timer;
        mip_lines[`IRQ_M_EXT]   = m_irq.external;
    end

    assign irq_active        = mip & mie;
    assign interrupt_pending = (|irq_active) && mstatus_mie;

    // External first, then timer, then software
    always_comb begin
        if (irq_active[`IRQ_M_EXT]) begin
            irq_cause = `ECODE_W'(`IRQ_M_EXT);
        end else if (irq_active[`IRQ_M_TIMER]) begin
            irq_cause = `ECODE_W'(`IRQ_M_TIMER);
        end else begin
            irq_cause = `ECODE_W'(`IRQ_M_SOFT);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_cause_r <= `ECODE_W'(`IRQ_M_SOFT);
        end else if (interrupt_pending) begin
            irq_cause_r <= irq_cause;
        end
    end

    //////////////////////////////
    // mcause

    assign mcause_write_legal = wr.data[`XLEN-1] ? IRQ_MASK[wr.data[`ECODE_W-1:0]]
                                                 : EXC_LEGAL[wr.data[`ECODE_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
        end else if (interrupt_taken) begin
            mcause_irq  <= 1'b1;
            mcause_code <= irq_cause_r;
        end else if (exception.valid) begin
            mcause_irq  <= 1'b0;
            mcause_code <= exception.code;
        end else if (wr.valid && (wr.addr == `CSR_MCAUSE) && mcause_write_legal) begin
            mcause_irq  <= wr.data[`XLEN-1];
            mcause_code <= wr.data[`ECODE_W-1:0];
        end
    end

    assign mcause = {mcause_irq, {(`XLEN-1-`ECODE_W){1'b0}}, mcause_code};

    assign trap = '{
        mstatus:  mstatus,
        mie:      mie,
        mip:      mip,
        mtvec:    mtvec,
        mepc:     mepc,
        mcause:   mcause,
        mscratch: mscratch
    };

    assign trap_vector = mtvec;
    assign epc         = mepc;

    // Covers codes from the core as well as filtered writes
    mcause_always_legal: assert property (@(posedge clk) disable iff (rst)
        (mcause_irq ? IRQ_MASK[mcause_code] : EXC_LEGAL[mcause_code]));

endmodule

// ==== hdl/csr_counters.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_counters
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  csr_write_t           wr,
    input  logic [`RETIRE_W-1:0] retire_count,
    output counter_csr_t         cnt
);

    logic [`COUNTER_W-1:0] mcycle;
    logic [`COUNTER_W-1:0] minstret;

    // A write to either half replaces that half and skips the increment
    function automatic logic [`COUNTER_W-1:0] counter_next(
        input logic [`COUNTER_W-1:0]  cur,
        input csr_write_t             w,
        input logic [`CSR_ADDR_W-1:0] lo_addr,
        input logic [`CSR_ADDR_W-1:0] hi_addr,
        input logic [`COUNTER_W-1:0]  inc
    );
        logic [`COUNTER_W-1:0] nxt;
        logic                  hit_lo;
        logic                  hit_hi;
        hit_lo = w.valid && (w.addr == lo_addr);
        hit_hi = w.valid && (w.addr == hi_addr);
        nxt = cur + inc;
        if (hit_lo || hit_hi) begin
            nxt = cur;
        end
        if (hit_lo) begin
            nxt[`XLEN-1:0] = w.data;
        end
        if (hit_hi) begin
            nxt[`COUNTER_W-1:`XLEN] = w.data;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= counter_next(mcycle, wr, `CSR_MCYCLE, `CSR_MCYCLEH, `COUNTER_W'(1));
            minstret <= counter_next(minstret, wr, `CSR_MINSTRET, `CSR_MINSTRETH,
                                     `COUNTER_W'(retire_count));
        end
    end

    assign cnt = '{mcycle: mcycle, minstret: minstret};

endmodule

// ==== hdl/csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // Requester port
    input  logic                 req,
    input  csr_req_t             req_data,
    output logic                 ack,
    output logic [`XLEN-1:0]     rdata,

    // Core side
    input  m_irq_t               m_irq,
    input  exception_t           exception,
    input  logic                 mret,
    input  logic                 interrupt_taken,
    input  logic [`RETIRE_W-1:0] retire_count,
    output logic [`XLEN-1:0]     trap_vector,
    output logic [`XLEN-1:0]     epc,
    output logic                 interrupt_pending
);

    logic             start;
    csr_req_t         cur_req;
    logic [`XLEN-1:0] old_value;
    csr_write_t       wr;
    trap_csr_t        trap;
    counter_csr_t     cnt;

    //////////////////////////////
    // Request pipeline

    csr_issue_stage issue0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rdata     (rdata),
        .old_value (old_value),
        .start     (start),
        .cur_req   (cur_req)
    );

    csr_rmw_stage rmw0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cur_req   (cur_req),
        .trap      (trap),
        .cnt       (cnt),
        .old_value (old_value),
        .wr        (wr)
    );

    //////////////////////////////
    // Register storage

    csr_trap_regs trap0 (
        .clk               (clk),
        .rst               (rst),
        .wr                (wr),
        .m_irq             (m_irq),
        .exception         (exception),
        .mret              (mret),
        .interrupt_taken   (interrupt_taken),
        .trap              (trap),
        .trap_vector       (trap_vector),
        .epc               (epc),
        .interrupt_pending (interrupt_pending)
    );

    csr_counters counters0 (
        .clk          (clk),
        .rst          (rst),
        .wr           (wr),
        .retire_count (retire_count),
        .cnt          (cnt)
    );

endmodule

// ==== testbench/csr_model.svh ====
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Expected register state that follows what the testbench drives
localparam logic [31:0] MODEL_MISA     = 32'h4000_0100;
localparam logic [31:0] MODEL_IRQ_BITS = 32'h0000_0888;

logic        exp_ms_mie;
logic        exp_ms_mpie;
logic [31:0] exp_mie;
logic [31:0] exp_mtvec;
logic [31:0] exp_mepc;
logic [31:0] exp_mcause;
logic [31:0] exp_mscratch;
logic [63:0] exp_minstret;
m_irq_t      exp_lines;

task automatic model_reset();
    exp_ms_mie   = 1'b0;
    exp_ms_mpie  = 1'b0;
    exp_mie      = 32'h0;
    exp_mtvec    = `RESET_MTVEC;
    exp_mepc     = 32'h0;
    exp_mcause   = 32'h0;
    exp_mscratch = 32'h0;
    exp_minstret = 64'h0;
    exp_lines    = '0;
endtask

function automatic logic [31:0] model_mip();
    return (32'(exp_lines.external) << `IRQ_M_EXT)
         | (32'(exp_lines.timer) << `IRQ_M_TIMER)
         | (32'(exp_lines.software) << `IRQ_M_SOFT);
endfunction

function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
        // MPP always machine
        `CSR_MSTATUS:   return 32'h1800 | (32'(exp_ms_mpie) << 7) | (32'(exp_ms_mie) << 3);
        `CSR_MISA:      return MODEL_MISA;
        `CSR_MIE:       return exp_mie;
        `CSR_MTVEC:     return exp_mtvec;
        `CSR_MSCRATCH:  return exp_mscratch;
        `CSR_MEPC:      return exp_mepc;
        `CSR_MCAUSE:    return exp_mcause;
        `CSR_MIP:       return model_mip();
        `CSR_MINSTRET:  return exp_minstret[31:0];
        `CSR_MINSTRETH: return exp_minstret[63:32];
        `CSR_MHARTID:   return `HART_ID;
        default:        return 32'h0;
    endcase
endfunction

// Machine interrupts 3, 7, 11 and exceptions 0, 2, 3, 4, 6, 11
function automatic logic cause_legal(input logic [31:0] value);
    if (value[31]) begin
        return value[4:0] inside {5'd3, 5'd7, 5'd11};
    end
    return value[4:0] inside {5'd0, 5'd2, 5'd3, 5'd4, 5'd6, 5'd11};
endfunction

task automatic model_access(input logic [11:0] addr, input csr_op_e op,
                            input logic [31:0] data, output logic [31:0] old);
    logic [31:0] nv;
    old = model_read(addr);
    case (op)
        CSR_RS:  nv = old | data;
        CSR_RC:  nv = old & ~data;
        default: nv = data;
    endcase
    // Set or clear with a zero mask only reads
    if (op == CSR_RW || data != 32'h0) begin
        case (addr)
            `CSR_MSTATUS: begin
                exp_ms_mie  = nv[3];
                exp_ms_mpie = nv[7];
            end
            `CSR_MIE:       exp_mie = nv & MODEL_IRQ_BITS;
            `CSR_MTVEC:     exp_mtvec = nv & ~32'h3;
            `CSR_MEPC:      exp_mepc = nv & ~32'h3;
            `CSR_MSCRATCH:  exp_mscratch = nv;
            `CSR_MCAUSE: begin
                if (cause_legal(nv)) begin
                    exp_mcause = {nv[31], 26'h0, nv[4:0]};
                end
            end
            `CSR_MINSTRET:  exp_minstret[31:0] = nv;
            `CSR_MINSTRETH: exp_minstret[63:32] = nv;
            default: ;
        endcase
    end
endtask

task automatic model_trap(input logic is_irq, input logic [4:0] code,
                          input logic [31:0] pc);
    exp_ms_mpie = exp_ms_mie;
    exp_ms_mie  = 1'b0;
    exp_mepc    = pc & ~32'h3;
    exp_mcause  = {is_irq, 26'h0, code};
endtask

task automatic model_mret();
    exp_ms_mie  = exp_ms_mpie;
    exp_ms_mpie = 1'b1;
endtask

// Highest enabled line wins in the order external, timer, software
function automatic logic [4:0] model_irq_code();
    logic [31:0] active;
    active = model_mip() & exp_mie;
    if (active[`IRQ_M_EXT]) begin
        return 5'd`IRQ_M_EXT;
    end
    if (active[`IRQ_M_TIMER]) begin
        return 5'd`IRQ_M_TIMER;
    end
    return 5'd`IRQ_M_SOFT;
endfunction

function automatic logic model_pending();
    return exp_ms_mie && ((model_mip() & exp_mie) != 32'h0);
endfunction

`endif

// ==== testbench/csr_unit_tb.sv ====
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit_tb
    import csr_pkg::*;
();

    // Cycles allowed for any single wait
    localparam int TIMEOUT = 200;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req;
    csr_req_t             req_data;
    logic                 ack;
    logic [`XLEN-1:0]     rdata;
    m_irq_t               m_irq;
    exception_t           exception;
    logic                 mret;
    logic                 interrupt_taken;
    logic [`RETIRE_W-1:0] retire_count;
    logic [`XLEN-1:0]     trap_vector;
    logic [`XLEN-1:0]     epc;
    logic                 interrupt_pending;

    int checks;
    int errors;
    int test_start_errors;
    bit abandoned;

    `include "csr_model.svh"

    csr_unit dut0 (
        .clk               (clk),
        .rst               (rst),
        .req               (req),
        .req_data          (req_data),
        .ack               (ack),
        .rdata             (rdata),
        .m_irq             (m_irq),
        .exception         (exception),
        .mret              (mret),
        .interrupt_taken   (interrupt_taken),
        .retire_count      (retire_count),
        .trap_vector       (trap_vector),
        .epc               (epc),
        .interrupt_pending (interrupt_pending)
    );

    always #4 clk = ~clk;

    //////////////////////////////
    // Checks and reporting

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (abandoned) return;
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s gave %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        if (abandoned) return;
        checks++;
        assert (cond === 1'b1) else begin
            $display("[FAIL] %0t: %s does not hold", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == test_start_errors) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    //////////////////////////////
    // Stimulus helpers

    function automatic csr_op_e random_op(input logic [1:0] sel);
        case (sel)
            2'd1:    return CSR_RS;
            2'd2:    return CSR_RC;
            default: return CSR_RW;
        endcase
    endfunction

    function automatic logic [4:0] legal_exc_code(input logic [2:0] sel);
        case (sel)
            3'd0:    return 5'd0;
            3'd1:    return 5'd2;
            3'd2:    return 5'd3;
            3'd3:    return 5'd4;
            3'd4:    return 5'd6;
            default: return 5'd11;
        endcase
    endfunction

    // One full four-phase transfer
    task automatic csr_access(input logic [11:0] addr, input csr_op_e op,
                              input logic [31:0] data, output logic [31:0] value);
        int waited;
        value = 32'h0;
        if (abandoned) return;
        @(posedge clk);
        req      <= 1'b1;
        req_data <= '{addr: addr, op: op, data: data};
        waited = 0;
        @(posedge clk);
        while (!ack && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!ack) begin
            $display("Timeout: the CSR unit never acknowledged a request to address %h", addr);
            abandoned = 1'b1;
            errors++;
            return;
        end
        value = rdata;
        req <= 1'b0;
        waited = 0;
        @(posedge clk);
        while (ack && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (ack) begin
            $display("Timeout: ack stayed high after req was dropped, address %h", addr);
            abandoned = 1'b1;
            errors++;
        end
    endtask

    task automatic access_and_check(input string what, input logic [11:0] addr,
                                    input csr_op_e op, input logic [31:0] data);
        logic [31:0] got;
        logic [31:0] expected;
        csr_access(addr, op, data, got);
        model_access(addr, op, data, expected);
        check_equal(what, got, expected);
    endtask

    task automatic read_and_check(input string what, input logic [11:0] addr);
        access_and_check(what, addr, CSR_RS, 32'h0);
    endtask

    // mip is registered, so allow a cycle to settle
    task automatic drive_lines(input m_irq_t lines);
        @(posedge clk);
        m_irq <= lines;
        exp_lines = lines;
        repeat (2) @(posedge clk);
    endtask

    task automatic pulse_interrupt(input logic [31:0] pc);
        @(posedge clk);
        interrupt_taken <= 1'b1;
        exception.pc    <= pc;
        @(posedge clk);
        interrupt_taken <= 1'b0;
        model_trap(1'b1, model_irq_code(), pc);
        @(posedge clk);
    endtask

    task automatic pulse_exception(input logic [4:0] code, input logic [31:0] pc);
        @(posedge clk);
        exception <= '{valid: 1'b1, code: code, pc: pc};
        @(posedge clk);
        exception.valid <= 1'b0;
        model_trap(1'b0, code, pc);
        @(posedge clk);
    endtask

    task automatic pulse_mret();
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
        model_mret();
        @(posedge clk);
    endtask

    task automatic retire_burst(input int cycles);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            r = $urandom;
            retire_count <= r[1:0];
            exp_minstret += 64'(r[1:0]);
        end
        @(posedge clk);
        retire_count <= '0;
    endtask

    //////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] r;
        logic [31:0] value;
        logic [31:0] got;
        logic [11:0] addr;
        void'($urandom(32'heeb8));
        $timeformat(-9, 0, " ns", 0);
        rst             = 1'b1;
        req             = 1'b0;
        req_data        = '0;
        m_irq           = '0;
        exception       = '0;
        mret            = 1'b0;
        interrupt_taken = 1'b0;
        retire_count    = '0;
        checks            = 0;
        errors            = 0;
        test_start_errors = 0;
        abandoned         = 1'b0;
        model_reset();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Plain storage registers through all three operations
        for (int i = 0; i < 40; i++) begin
            r = $urandom;
            case (r[1:0])
                2'd0:    addr = `CSR_MSCRATCH;
                2'd1:    addr = `CSR_MIE;
                2'd2:    addr = `CSR_MTVEC;
                default: addr = `CSR_MEPC;
            endcase
            access_and_check("old value", addr, random_op(r[3:2]), $urandom);
            read_and_check("read back", addr);
        end
        check_equal("trap_vector", trap_vector, exp_mtvec);
        report_test("Test 1 read-modify-write");

        r = $urandom;
        drive_lines(m_irq_t'(r[2:0]));
        read_and_check("misa", `CSR_MISA);
        read_and_check("mhartid", `CSR_MHARTID);
        access_and_check("misa write", `CSR_MISA, CSR_RW, $urandom);
        access_and_check("mhartid write", `CSR_MHARTID, CSR_RW, $urandom);
        access_and_check("mip write", `CSR_MIP, CSR_RS, $urandom);
        read_and_check("misa after write", `CSR_MISA);
        read_and_check("mhartid after write", `CSR_MHARTID);
        read_and_check("mip after write", `CSR_MIP);
        drive_lines('0);
        report_test("Test 2 read-only registers");

        for (int i = 0; i < 24; i++) begin
            r = $urandom;
            value = {r[31], r[30:5], 5'(r % 13)};
            access_and_check("mcause write", `CSR_MCAUSE, CSR_RW, value);
            read_and_check("mcause", `CSR_MCAUSE);
        end
        report_test("Test 3 mcause legality");

        access_and_check("mstatus set", `CSR_MSTATUS, CSR_RW, 32'h8);
        for (int i = 0; i < 16; i++) begin
            r = $urandom;
            access_and_check("mie write", `CSR_MIE, CSR_RW, r);
            drive_lines(m_irq_t'(r[14:12]));
            check_true("interrupt_pending match", interrupt_pending === model_pending());
        end
        access_and_check("mie enable all", `CSR_MIE, CSR_RW, 32'h888);
        r = $urandom;
        drive_lines(m_irq_t'(3'(r % 7) + 3'd1));
        check_true("interrupt_pending before trap", interrupt_pending === 1'b1);
        pulse_interrupt($urandom);
        check_equal("epc after interrupt", epc, exp_mepc);
        read_and_check("mcause after interrupt", `CSR_MCAUSE);
        read_and_check("mstatus after interrupt", `CSR_MSTATUS);
        check_true("interrupt_pending low after trap", interrupt_pending === 1'b0);
        drive_lines('0);
        pulse_mret();
        read_and_check("mstatus after mret", `CSR_MSTATUS);
        r = $urandom;
        pulse_exception(legal_exc_code(r[2:0]), $urandom);
        check_equal("epc after exception", epc, exp_mepc);
        read_and_check("mcause after exception", `CSR_MCAUSE);
        read_and_check("mstatus after exception", `CSR_MSTATUS);
        pulse_mret();
        read_and_check("mstatus after second mret", `CSR_MSTATUS);
        report_test("Test 4 interrupts and traps");

        // Start just below the top of the low half so the bursts carry into minstreth
        access_and_check("minstret write", `CSR_MINSTRET, CSR_RW, 32'hFFFF_FFF0);
        for (int i = 0; i < 6; i++) begin
            r = $urandom;
            retire_burst(int'(r[4:0]) + 1);
            read_and_check("minstret", `CSR_MINSTRET);
            read_and_check("minstreth", `CSR_MINSTRETH);
        end
        r = $urandom;
        value = r & 32'h0FFF_FFFF;
        csr_access(`CSR_MCYCLE, CSR_RW, value, got);
        csr_access(`CSR_MCYCLE, CSR_RS, 32'h0, got);
        check_true("mcycle range after write", (got >= value) && (got < value + TIMEOUT));
        report_test("Test 5 counters");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !abandoned) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
+incdir+hdl
+incdir+testbench
hdl/csr_pkg.sv
hdl/csr_issue_stage.sv
hdl/csr_rmw_stage.sv
hdl/csr_trap_regs.sv
hdl/csr_counters.sv
hdl/csr_unit.sv
testbench/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -j 0 \
    --top-module csr_unit_tb -f csr_unit.f -o csr_unit_sim > build.log 2>&1 \
    && ./obj_dir/csr_unit_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }

cat sim.log

# The testbench prints its verdict as the last line of the log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
